// File: huff_cfg.svh
`ifndef HUFF_CFG_SVH
`define HUFF_CFG_SVH

// Number of coded symbols
`define HUFF_NSYM 6

// Width of each frequency counter
`define HUFF_CW 8

// Width of each code and its mask
`define HUFF_CODEW 8

// Symbol value that lands on group bit 0
`define HUFF_SYM_BASE 1

`endif

// File: huff_pkg.sv
`include "huff_cfg.svh"

package huff_pkg;

	// Frame sequencing states
	typedef enum logic [2:0] {
		IDLE,
		COUNT,
		PUBLISH,
		SORT,
		MERGE,
		DONE
	} ctrl_state_t;

	// One entry of the sort bank, group has one bit per symbol
	typedef struct packed {
		logic [`HUFF_CW-1:0]   count;
		logic [`HUFF_NSYM-1:0] group;
	} sort_item_t;

	// Position 0 holds the largest count
	typedef sort_item_t [`HUFF_NSYM-1:0] item_vec_t;

	// Indexed by symbol minus base
	typedef logic [`HUFF_NSYM-1:0][`HUFF_CW-1:0] count_vec_t;

	// Code bits and the mask of valid bits
	typedef struct packed {
		logic [`HUFF_CODEW-1:0] hc;
		logic [`HUFF_CODEW-1:0] mask;
	} code_t;

	typedef code_t [`HUFF_NSYM-1:0] code_vec_t;

	// Number of live items in the bank
	typedef logic [2:0] live_t;

endpackage

// File: huffman_ctrl.sv
`include "huff_cfg.svh"

module huffman_ctrl
	import huff_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  in_valid,
	input  logic  sort_done,
	output logic  frame_start,
	output logic  count_en,
	output logic  sort_load,
	output logic  sort_merge,
	output logic  code_en,
	output logic  cnt_valid,
	output logic  code_valid,
	output live_t live
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (in_valid)
					state_nxt = COUNT;
			end
			COUNT: begin
				// Frame ends on the first low in_valid
				if (!in_valid)
					state_nxt = PUBLISH;
			end
			PUBLISH: state_nxt = SORT;
			SORT: begin
				if (sort_done)
					state_nxt = MERGE;
			end
			MERGE: begin
				// Last merge leaves a single item
				if (live == live_t'(2))
					state_nxt = DONE;
				else
					state_nxt = SORT;
			end
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			live <= live_t'(`HUFF_NSYM);
		end else begin
			state <= state_nxt;
			if (state == PUBLISH)
				live <= live_t'(`HUFF_NSYM);
			else if (state == MERGE)
				live <= live - live_t'(1);
		end
	end

	// Strobes decoded from the current state
	assign frame_start = (state == IDLE) && in_valid;
	assign count_en    = in_valid && ((state == IDLE) || (state == COUNT));
	assign sort_load   = (state == PUBLISH);
	assign sort_merge  = (state == MERGE);
	assign code_en     = (state == MERGE);
	assign cnt_valid   = (state == PUBLISH);
	assign code_valid  = (state == DONE);

endmodule

// File: symbol_counter.sv
`include "huff_cfg.svh"

module symbol_counter
	import huff_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       count_en,
	input  logic       frame_start,
	input  logic [7:0] in_sym,
	output count_vec_t counts
);

	logic [7:0] sym_idx;
	count_vec_t counts_nxt;

	// Values below the base wrap high and miss every slot
	assign sym_idx = in_sym - 8'(`HUFF_SYM_BASE);

	always_comb begin
		counts_nxt = frame_start ? '0 : counts;
		if (count_en) begin
			for (int s = 0; s < `HUFF_NSYM; s++) begin
				if (sym_idx == 8'(s))
					counts_nxt[s] = counts_nxt[s] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			counts <= '0;
		else
			counts <= counts_nxt;
	end

endmodule

// File: sort_array.sv
`include "huff_cfg.svh"

module sort_array
	import huff_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       sort_load,
	input  logic       sort_merge,
	input  live_t      live,
	input  count_vec_t counts,
	input  sort_item_t merged,
	output item_vec_t  items,
	output logic       sort_done
);

	item_vec_t load_v;
	item_vec_t even_v;
	item_vec_t pass_v;
	item_vec_t merge_v;

	// Swap pair (i, i+1) when both are live and the lower one is larger
	// Equal counts stay put, which keeps the sort stable
	function automatic item_vec_t cmp_xchg(input item_vec_t v, input int i, input live_t n);
		item_vec_t r;
		r = v;
		if ((i + 1 < int'(n)) && (v[i].count < v[i+1].count)) begin
			r[i]   = v[i+1];
			r[i+1] = v[i];
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < `HUFF_NSYM; i++) begin
			load_v[i].count = counts[i];
			load_v[i].group = `HUFF_NSYM'(1) << i;
		end
	end

	// One full pass, even pairs first, then odd pairs
	always_comb begin
		even_v = items;
		for (int i = 0; i < `HUFF_NSYM - 1; i += 2)
			even_v = cmp_xchg(even_v, i, live);
		pass_v = even_v;
		for (int i = 1; i < `HUFF_NSYM - 1; i += 2)
			pass_v = cmp_xchg(pass_v, i, live);
	end

	// Merged item replaces the second-to-last live slot
	always_comb begin
		merge_v = items;
		merge_v[live - live_t'(2)] = merged;
	end

	assign sort_done = !sort_load && (pass_v == items);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			items <= '0;
		else if (sort_load)
			items <= load_v;
		else if (sort_merge)
			items <= merge_v;
		else
			items <= pass_v;
	end

endmodule

// File: merge_select.sv
`include "huff_cfg.svh"

module merge_select
	import huff_pkg::*;
(
	input  item_vec_t             items,
	input  live_t                 live,
	output logic [`HUFF_NSYM-1:0] grp_a,
	output logic [`HUFF_NSYM-1:0] grp_b,
	output sort_item_t            merged
);

	sort_item_t item_a;
	sort_item_t item_b;

	// A is second-to-last, B is last
	always_comb begin
		item_a = '0;
		item_b = '0;
		if (live >= live_t'(2)) begin
			item_a = items[live - live_t'(2)];
			item_b = items[live - live_t'(1)];
		end
	end

	assign grp_a = item_a.group;
	assign grp_b = item_b.group;

	assign merged.count = item_a.count + item_b.count;
	assign merged.group = item_a.group | item_b.group;

endmodule

// File: code_builder.sv
`include "huff_cfg.svh"

module code_builder
	import huff_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frame_start,
	input  logic                  code_en,
	input  logic [`HUFF_NSYM-1:0] grp_a,
	input  logic [`HUFF_NSYM-1:0] grp_b,
	output code_vec_t             codes
);

	code_vec_t codes_nxt;

	// New bit goes just above the current code length
	// B side gets a 1, A side a 0
	always_comb begin
		codes_nxt = codes;
		for (int s = 0; s < `HUFF_NSYM; s++) begin
			if (grp_a[s] || grp_b[s]) begin
				codes_nxt[s].hc[$countones(codes[s].mask)] = grp_b[s];
				codes_nxt[s].mask = {codes[s].mask[`HUFF_CODEW-2:0], 1'b1};
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			codes <= '0;
		else if (frame_start)
			codes <= '0;
		else if (code_en)
			codes <= codes_nxt;
	end

endmodule

// File: huffman_top.sv
`include "huff_cfg.svh"

module huffman_top
	import huff_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  logic [7:0] in_sym,
	output logic       cnt_valid,
	output count_vec_t counts,
	output logic       code_valid,
	output code_vec_t  codes
);

	logic                  frame_start;
	logic                  count_en;
	logic                  sort_load;
	logic                  sort_merge;
	logic                  sort_done;
	logic                  code_en;
	live_t                 live;
	item_vec_t             items;
	sort_item_t            merged;
	logic [`HUFF_NSYM-1:0] grp_a;
	logic [`HUFF_NSYM-1:0] grp_b;

	huffman_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.sort_done   (sort_done),
		.frame_start (frame_start),
		.count_en    (count_en),
		.sort_load   (sort_load),
		.sort_merge  (sort_merge),
		.code_en     (code_en),
		.cnt_valid   (cnt_valid),
		.code_valid  (code_valid),
		.live        (live)
	);

	symbol_counter u_counter (
		.clk         (clk),
		.rst         (rst),
		.count_en    (count_en),
		.frame_start (frame_start),
		.in_sym      (in_sym),
		.counts      (counts)
	);

	sort_array u_sort (
		.clk        (clk),
		.rst        (rst),
		.sort_load  (sort_load),
		.sort_merge (sort_merge),
		.live       (live),
		.counts     (counts),
		.merged     (merged),
		.items      (items),
		.sort_done  (sort_done)
	);

	merge_select u_merge (
		.items  (items),
		.live   (live),
		.grp_a  (grp_a),
		.grp_b  (grp_b),
		.merged (merged)
	);

	code_builder u_code (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.code_en     (code_en),
		.grp_a       (grp_a),
		.grp_b       (grp_b),
		.codes       (codes)
	);

endmodule

// File: tb_clk.sv
module tb_clk #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	// Free-running, first rising edge at half a period
	always #(PERIOD / 2) clk = ~clk;

endmodule

// File: huffman_sva.sv
module huffman_sva (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic cnt_valid,
	input logic code_valid
);

	// High from the count pulse until the code pulse
	logic result_pending;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			result_pending <= 1'b0;
		else if (cnt_valid)
			result_pending <= 1'b1;
		else if (code_valid)
			result_pending <= 1'b0;
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		!(cnt_valid && code_valid))
		else $error("cnt_valid and code_valid high in the same cycle");

	a_cnt_pulse: assert property (@(posedge clk) disable iff (rst) cnt_valid |=> !cnt_valid)
		else $error("cnt_valid held for more than one cycle");

	a_code_pulse: assert property (@(posedge clk) disable iff (rst) code_valid |=> !code_valid)
		else $error("code_valid held for more than one cycle");

	// Stimulus must wait for the codes before the next frame
	a_no_early_frame: assert property (@(posedge clk) disable iff (rst)
		(cnt_valid || result_pending) |-> !$rose(in_valid))
		else $error("in_valid rose before code_valid of the previous frame");

endmodule

bind huffman_top huffman_sva u_sva (
	.clk        (clk),
	.rst        (rst),
	.in_valid   (in_valid),
	.cnt_valid  (cnt_valid),
	.code_valid (code_valid)
);

// File: huffman_tb.sv
`include "huff_cfg.svh"

module huffman_tb
	import huff_pkg::*;
();

	localparam int NUM_FRAMES = 40;
	localparam int MAX_LEN    = 200;
	localparam int CLK_PERIOD = 4;
	localparam int DONE_LIMIT = 64;
	localparam int WATCHDOG_T = (NUM_FRAMES * (MAX_LEN + 64) + 32) * CLK_PERIOD;

	logic       clk;
	logic       rst;
	logic       in_valid;
	logic [7:0] in_sym;
	logic       cnt_valid;
	logic       code_valid;
	count_vec_t counts;
	code_vec_t  codes;

	int         cnt_total = 0;
	int         code_total = 0;
	time        cnt_time;
	time        code_time;
	count_vec_t cnt_snap;
	code_vec_t  code_snap;
	int         test_errs = 0;
	int         tests_run = 0;
	int         tests_failed = 0;

	tb_clk #(.PERIOD(CLK_PERIOD)) clk_gen (.clk(clk));

	huffman_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_sym     (in_sym),
		.cnt_valid  (cnt_valid),
		.counts     (counts),
		.code_valid (code_valid),
		.codes      (codes)
	);

	// Pulse monitor on the falling edge, away from the drive point
	always @(negedge clk) begin
		if (!rst && cnt_valid) begin
			cnt_total++;
			cnt_time = $time;
			cnt_snap = counts;
			code_snap = codes;
		end
		if (!rst && code_valid) begin
			code_total++;
			code_time = $time;
		end
	end

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// Kind 0 repeats one symbol, kind 1 leaves most counts at zero
	function automatic int random_symbol(input int kind);
		int r;
		r = $urandom % 8;
		case (kind)
			0: return 3;
			1: return (r < 3) ? 2 : (r < 6) ? 5 : (r == 6) ? 0 : 8;
			default: begin
				if (r != 0)
					return 1 + $urandom % 6;
				r = $urandom % 4;
				return (r == 0) ? 0 : 6 + r;
			end
		endcase
	endfunction

	// Stable descending sort, merge the last two, prepend 0 to A and 1 to B
	function automatic code_vec_t model_codes(input count_vec_t cnt);
		int                    icnt[`HUFF_NSYM];
		logic [`HUFF_NSYM-1:0] igrp[`HUFF_NSYM];
		int                    len[`HUFF_NSYM];
		int                    tc;
		logic [`HUFF_NSYM-1:0] tg;
		code_vec_t             res;
		res = '0;
		for (int i = 0; i < `HUFF_NSYM; i++) begin
			icnt[i] = int'(cnt[i]);
			igrp[i] = `HUFF_NSYM'(1) << i;
			len[i] = 0;
		end
		for (int n = `HUFF_NSYM; n > 1; n--) begin
			for (int i = 1; i < n; i++) begin
				for (int j = i; j > 0 && icnt[j-1] < icnt[j]; j--) begin
					tc = icnt[j];
					tg = igrp[j];
					icnt[j] = icnt[j-1];
					igrp[j] = igrp[j-1];
					icnt[j-1] = tc;
					igrp[j-1] = tg;
				end
			end
			for (int s = 0; s < `HUFF_NSYM; s++) begin
				if (igrp[n-2][s] || igrp[n-1][s]) begin
					res[s].hc[len[s]] = igrp[n-1][s];
					res[s].mask = {res[s].mask[`HUFF_CODEW-2:0], 1'b1};
					len[s]++;
				end
			end
			icnt[n-2] = icnt[n-2] + icnt[n-1];
			igrp[n-2] = igrp[n-2] | igrp[n-1];
		end
		return res;
	endfunction

	task automatic run_frame(input int idx, input int kind);
		int         len;
		int         sym;
		int         waited;
		int         cnt_before;
		int         code_before;
		int         tally[`HUFF_NSYM];
		count_vec_t exp_counts;
		code_vec_t  exp_codes;
		string      name;
		name = $sformatf("frame_%0d", idx);
		cnt_before = cnt_total;
		code_before = code_total;
		foreach (tally[s])
			tally[s] = 0;
		len = 1 + $urandom % MAX_LEN;
		for (int i = 0; i < len; i++) begin
			sym = random_symbol(kind);
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			in_sym = 8'(sym);
			if (sym >= `HUFF_SYM_BASE && sym < `HUFF_SYM_BASE + `HUFF_NSYM)
				tally[sym - `HUFF_SYM_BASE]++;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_sym = '0;
		waited = 0;
		while (code_total == code_before && waited < DONE_LIMIT) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (code_total == code_before) begin
			$display("%s: no code_valid within %0d cycles after the frame", name, DONE_LIMIT);
			test_errs++;
		end
		for (int s = 0; s < `HUFF_NSYM; s++)
			exp_counts[s] = `HUFF_CW'(tally[s]);
		exp_codes = model_codes(exp_counts);
		check_value({name, " cnt_valid pulses"}, 1, cnt_total - cnt_before);
		check_value({name, " code_valid pulses"}, 1, code_total - code_before);
		check_value({name, " pulse order"}, 1, cnt_time < code_time);
		check_value({name, " counts"}, exp_counts, cnt_snap);
		check_value({name, " codes cleared at cnt_valid"}, 0, code_snap);
		for (int s = 0; s < `HUFF_NSYM; s++) begin
			check_value($sformatf("%s sym%0d mask", name, s + 1), exp_codes[s].mask,
				codes[s].mask);
			check_value($sformatf("%s sym%0d hc", name, s + 1), exp_codes[s].hc, codes[s].hc);
		end
		end_test(name);
	endtask

	initial begin
		int seed_ret;
		rst = 1'b1;
		in_valid = 1'b0;
		in_sym = '0;
		seed_ret = $urandom(31597);
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// Idle stretch with no frame
		repeat (10) @(posedge clk);
		#1;
		check_value("reset_idle cnt_valid pulses", 0, cnt_total);
		check_value("reset_idle code_valid pulses", 0, code_total);
		check_value("reset_idle counts", 0, counts);
		check_value("reset_idle codes", 0, codes);
		end_test("reset_idle");
		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f, (f < 2) ? f : 2);
		$display("tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_T);
		$display("Watchdog expired after %0d time units, the DUT stopped responding",
			WATCHDOG_T);
		$display("Test failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+.
huff_pkg.sv
huffman_ctrl.sv
symbol_counter.sv
sort_array.sv
merge_select.sv
code_builder.sv
huffman_top.sv
tb_clk.sv
huffman_sva.sv
huffman_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= huffman_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
